// File: Makefile
TOP = rs_encode_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module rs_encode
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// File: fec_pkg.sv
package fec_pkg;

    // ========================================
    // Code shape
    // ========================================

    // Symbol width in bits
    localparam int SYM_SIZE = 8;
    // Message symbols per block
    localparam int RS_K     = 8;
    // Parity symbols, corrects RS_2T/2 symbol errors
    localparam int RS_2T    = 4;
    localparam int RS_N     = RS_K + RS_2T;

    // x^8 + x^4 + x^3 + x^2 + 1
    localparam logic [SYM_SIZE:0] GF_POLY = 9'h11D;

    // ========================================
    // Types
    // ========================================

    typedef logic [SYM_SIZE-1:0] sym_t;

    // Index 0 is the first symbol sent, highest degree
    typedef sym_t [RS_K-1:0]  data_blk_t;

    // Index 0 is the lowest degree parity coefficient
    typedef sym_t [RS_2T-1:0] parity_blk_t;

    // ========================================
    // GF(2^8) arithmetic
    // ========================================

    // Shift and add multiply, reduced on every doubling
    function automatic sym_t gf_mul(sym_t a, sym_t b);
        sym_t acc;
        sym_t aa;
        acc = '0;
        aa  = a;
        for (int i = 0; i < SYM_SIZE; i++) begin
            if (b[i])
                acc = acc ^ aa;
            // Multiply aa by alpha
            aa = aa[SYM_SIZE-1] ? ((aa << 1) ^ GF_POLY[SYM_SIZE-1:0]) : (aa << 1);
        end
        return acc;
    endfunction

    // Product of (x - alpha^i) for i = 0..RS_2T-1, leading 1 dropped
    function automatic parity_blk_t rs_gen_poly();
        sym_t        g [RS_2T+1];
        sym_t        root;
        parity_blk_t res;
        for (int j = 0; j <= RS_2T; j++)
            g[j] = '0;
        g[0] = 8'h01;
        root = 8'h01;
        for (int i = 0; i < RS_2T; i++) begin
            // Multiply running polynomial by (x + root)
            for (int j = RS_2T; j > 0; j--)
                g[j] = g[j-1] ^ gf_mul(g[j], root);
            g[0] = gf_mul(g[0], root);
            root = gf_mul(root, 8'h02);
        end
        for (int j = 0; j < RS_2T; j++)
            res[j] = g[j];
        return res;
    endfunction

    // g0..g3, expected 0x40 0x78 0x36 0x0F
    localparam parity_blk_t RS_GEN = rs_gen_poly();

endpackage

// File: flist.f
+incdir+.
fec_pkg.sv
rs_in_skid.sv
rs_lfsr_stage.sv
rs_encode.sv
rs_encode_tb.sv

// File: rs_encode.sv
`timescale 1ns/10ps

module rs_encode (
    input  logic                 clk,
    input  logic                 rst,
    input  fec_pkg::data_blk_t   data_in,
    input  logic                 data_in_valid,
    output logic                 data_in_ready,
    output fec_pkg::data_blk_t   data_out,
    output fec_pkg::parity_blk_t parity_out,
    output logic                 data_out_valid,
    input  logic                 data_out_ready
);

    // ========================================
    // Links between pipeline stages
    // ========================================

    // Link 0 is the skid output, link RS_K the last stage output
    fec_pkg::data_blk_t   blk_link [fec_pkg::RS_K+1];
    fec_pkg::parity_blk_t rem_link [fec_pkg::RS_K+1];
    logic [fec_pkg::RS_K:0] vld_link;
    logic [fec_pkg::RS_K:0] rdy_link;

    // Division starts from an empty remainder
    assign rem_link[0] = '0;

    // ========================================
    // Input skid buffer
    // ========================================
    rs_in_skid u_skid (
        .clk           (clk),
        .rst           (rst),
        .data_in       (data_in),
        .data_in_valid (data_in_valid),
        .data_in_ready (data_in_ready),
        .blk_out       (blk_link[0]),
        .blk_out_valid (vld_link[0]),
        .blk_out_ready (rdy_link[0])
    );

    // ========================================
    // One stage per message symbol
    // ========================================
    for (genvar i = 0; i < fec_pkg::RS_K; i++) begin : g_stage
        rs_lfsr_stage #(
            .STAGE_IDX (i)
        ) u_stage (
            .clk       (clk),
            .rst       (rst),
            .blk_in    (blk_link[i]),
            .rem_in    (rem_link[i]),
            .in_valid  (vld_link[i]),
            .in_ready  (rdy_link[i]),
            .blk_out   (blk_link[i+1]),
            .rem_out   (rem_link[i+1]),
            .out_valid (vld_link[i+1]),
            .out_ready (rdy_link[i+1])
        );
    end

    // Last stage faces the sink
    assign rdy_link[fec_pkg::RS_K] = data_out_ready;

    // Message passes untouched, parity is the final remainder
    assign data_out       = blk_link[fec_pkg::RS_K];
    assign parity_out     = rem_link[fec_pkg::RS_K];
    assign data_out_valid = vld_link[fec_pkg::RS_K];

endmodule

// File: rs_tb_util.svh
`ifndef RS_TB_UTIL_SVH
`define RS_TB_UTIL_SVH

// ========================================
// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
// ========================================

typedef logic [15:0] tb_lfsr_t;

// One step, one bit out
function automatic logic lfsr_bit(inout tb_lfsr_t st);
    logic b;
    b  = st[0];
    st = st >> 1;
    if (b)
        st = st ^ 16'hB400;
    return b;
endfunction

// Eight steps per symbol
function automatic fec_pkg::sym_t lfsr_sym(inout tb_lfsr_t st);
    fec_pkg::sym_t s;
    for (int i = 0; i < fec_pkg::SYM_SIZE; i++)
        s[i] = lfsr_bit(st);
    return s;
endfunction

// Random message block
function automatic fec_pkg::data_blk_t rand_blk(inout tb_lfsr_t st);
    fec_pkg::data_blk_t blk;
    for (int i = 0; i < fec_pkg::RS_K; i++)
        blk[i] = lfsr_sym(st);
    return blk;
endfunction

// ========================================
// Syndrome, codeword evaluated at alpha^idx
// ========================================

function automatic fec_pkg::sym_t rs_syndrome(fec_pkg::data_blk_t d,
                                              fec_pkg::parity_blk_t p, int idx);
    fec_pkg::sym_t x;
    fec_pkg::sym_t acc;
    x   = 8'h01;
    acc = '0;
    for (int i = 0; i < idx; i++)
        x = fec_pkg::gf_mul(x, 8'h02);
    // Horner, message first then parity top down
    for (int i = 0; i < fec_pkg::RS_K; i++)
        acc = fec_pkg::gf_mul(acc, x) ^ d[i];
    for (int i = fec_pkg::RS_2T - 1; i >= 0; i--)
        acc = fec_pkg::gf_mul(acc, x) ^ p[i];
    return acc;
endfunction

`endif

// File: rs_encode_tb.sv
`timescale 1ns/10ps

`include "rs_tb_util.svh"

module rs_encode_tb;

    localparam int TIMEOUT  = 2000;
    localparam int N_RANDOM = 300;
    localparam int N_BURST  = 24;
    // Skid buffer plus one register per stage
    localparam int LATENCY  = fec_pkg::RS_K + 1;

    logic                 clk;
    logic                 rst;
    fec_pkg::data_blk_t   data_in;
    logic                 data_in_valid;
    logic                 data_in_ready;
    fec_pkg::data_blk_t   data_out;
    fec_pkg::parity_blk_t parity_out;
    logic                 data_out_valid;
    logic                 data_out_ready;

    // Stimulus state
    tb_lfsr_t lfsr;
    logic     rand_ready;
    logic     full_rate;

    // Scoreboard, accepted blocks and their accept cycles
    fec_pkg::data_blk_t exp_q [$];
    int                 acc_cyc_q [$];
    int                 cyc = 0;
    int                 last_out_cyc = 0;
    int                 burst_outs = 0;

    rs_encode dut0 (
        .clk            (clk),
        .rst            (rst),
        .data_in        (data_in),
        .data_in_valid  (data_in_valid),
        .data_in_ready  (data_in_ready),
        .data_out       (data_out),
        .parity_out     (parity_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("** Error at time %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_timeout(input string msg);
        $display("Timeout after %0d cycles: %s", TIMEOUT, msg);
        $display("Test failed");
        $fatal(1);
    endtask

    // Step to the drive point, new random ready bit if enabled
    task automatic next_cycle();
        @(posedge clk);
        #10;
        if (rand_ready)
            data_out_ready = lfsr_bit(lfsr);
    endtask

    // Present one block, return once it has been taken
    task automatic send_block(input fec_pkg::data_blk_t blk);
        logic ok;
        ok            = 1'b0;
        data_in       = blk;
        data_in_valid = 1'b1;
        for (int t = 0; t < TIMEOUT && !ok; t++) begin
            // Registered ready, steady by mid cycle
            @(negedge clk);
            ok = data_in_ready;
            next_cycle();
        end
        if (!ok)
            report_timeout("data_in_ready never rose");
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_q.size() != 0) begin
            if (t == TIMEOUT)
                report_timeout("accepted blocks never left the pipeline");
            next_cycle();
            t++;
        end
    endtask

    // ========================================
    // Concurrent checks
    // ========================================
    assert property (@(posedge clk) rst && $past(rst) |-> !data_out_valid)
        else report_error("data_out_valid high during reset");
    assert property (@(posedge clk) $fell(rst) |-> !data_out_valid && data_in_ready)
        else report_error("wrong valid or ready on first cycle after reset");
    // Stalled output must not move
    assert property (@(posedge clk) disable iff (rst)
        data_out_valid && !data_out_ready |=>
            data_out_valid && $stable(data_out) && $stable(parity_out))
        else report_error("output changed while stalled");
    assert property (@(posedge clk) disable iff (rst) full_rate |-> data_in_ready)
        else report_error("data_in_ready dropped at full rate");

    // ========================================
    // Scoreboard, transfers judged mid cycle
    // ========================================
    always @(negedge clk) begin : monitor
        fec_pkg::data_blk_t exp_blk;
        int                 acc_cyc;
        cyc = cyc + 1;
        if (!rst && data_in_valid && data_in_ready) begin
            exp_q.push_back(data_in);
            acc_cyc_q.push_back(cyc);
        end
        if (!rst && data_out_valid && data_out_ready) begin
            assert (exp_q.size() > 0)
                else report_error("output transfer with no block outstanding");
            exp_blk = exp_q.pop_front();
            acc_cyc = acc_cyc_q.pop_front();
            assert (data_out == exp_blk)
                else report_error($sformatf("data_out %h, expected %h", data_out, exp_blk));
            // Every root of the generator must be a root of the codeword
            for (int i = 0; i < fec_pkg::RS_2T; i++)
                assert (rs_syndrome(data_out, parity_out, i) == '0)
                    else report_error($sformatf("syndrome %0d nonzero, parity %h", i, parity_out));
            if (exp_blk == '0)
                assert (parity_out == '0)
                    else report_error($sformatf("zero block gave parity %h", parity_out));
            if (full_rate) begin
                assert (cyc - acc_cyc == LATENCY)
                    else report_error($sformatf("latency %0d cycles", cyc - acc_cyc));
                if (burst_outs > 0)
                    assert (cyc == last_out_cyc + 1)
                        else report_error("gap between full rate outputs");
                burst_outs++;
            end
            last_out_cyc = cyc;
        end
    end

    initial begin
        rst            = 1'b1;
        data_in        = '0;
        data_in_valid  = 1'b0;
        data_out_ready = 1'b1;
        rand_ready     = 1'b0;
        full_rate      = 1'b0;
        lfsr           = 16'd9717;
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;

        // Random blocks, random sink stalls
        rand_ready = 1'b1;
        for (int n = 0; n < N_RANDOM; n++)
            send_block(rand_blk(lfsr));
        send_block('0);
        data_in_valid = 1'b0;
        wait_drain();

        // Back to back, sink always ready
        rand_ready     = 1'b0;
        data_out_ready = 1'b1;
        full_rate      = 1'b1;
        for (int n = 0; n < N_BURST; n++)
            send_block(rand_blk(lfsr));
        data_in_valid = 1'b0;
        wait_drain();

        // Idle long enough to expose a duplicate
        repeat (2 * fec_pkg::RS_N) next_cycle();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: rs_in_skid.sv
`timescale 1ns/10ps

module rs_in_skid (
    input  logic               clk,
    input  logic               rst,
    input  fec_pkg::data_blk_t data_in,
    input  logic               data_in_valid,
    output logic               data_in_ready,
    output fec_pkg::data_blk_t blk_out,
    output logic               blk_out_valid,
    input  logic               blk_out_ready
);

    // Main entry drives the output, spare absorbs one stalled block
    fec_pkg::data_blk_t main_blk;
    fec_pkg::data_blk_t spare_blk;
    logic               main_valid;
    logic               spare_valid;
    logic               main_valid_nxt;
    logic               spare_valid_nxt;
    logic               ready_q;
    logic               accept;
    logic               load_main;

    assign accept    = data_in_valid & data_in_ready;
    // Main entry free or leaving this cycle
    assign load_main = ~main_valid | blk_out_ready;

    // ========================================
    // Occupancy
    // ========================================
    always_comb begin
        main_valid_nxt  = main_valid;
        spare_valid_nxt = spare_valid;
        if (load_main) begin
            if (spare_valid) begin
                // Spare drains first, input is blocked meanwhile
                main_valid_nxt  = 1'b1;
                spare_valid_nxt = 1'b0;
            end else begin
                main_valid_nxt = accept;
            end
        end else if (accept) begin
            // Downstream stalled, park the new block
            spare_valid_nxt = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
            ready_q     <= 1'b1;
        end else begin
            main_valid  <= main_valid_nxt;
            spare_valid <= spare_valid_nxt;
            // Ready straight from a flop, no path from blk_out_ready
            ready_q     <= ~spare_valid_nxt;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (load_main)
            main_blk <= spare_valid ? spare_blk : data_in;
        else if (accept)
            spare_blk <= data_in;
    end

    assign data_in_ready = ready_q;
    assign blk_out       = main_blk;
    assign blk_out_valid = main_valid;

endmodule

// File: rs_lfsr_stage.sv
`timescale 1ns/10ps

module rs_lfsr_stage #(
    parameter int STAGE_IDX = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  fec_pkg::data_blk_t   blk_in,
    input  fec_pkg::parity_blk_t rem_in,
    input  logic                 in_valid,
    output logic                 in_ready,
    output fec_pkg::data_blk_t   blk_out,
    output fec_pkg::parity_blk_t rem_out,
    output logic                 out_valid,
    input  logic                 out_ready
);

    fec_pkg::sym_t        msg_sym;
    fec_pkg::sym_t        fb;
    fec_pkg::parity_blk_t rem_next;
    fec_pkg::data_blk_t   blk_q;
    fec_pkg::parity_blk_t rem_q;
    logic                 valid_q;
    logic                 load;

    // ========================================
    // Division step
    // ========================================

    // Message symbol handled by this stage
    assign msg_sym = blk_in[STAGE_IDX];

    // Feedback, new symbol plus top of remainder
    assign fb = msg_sym ^ rem_in[fec_pkg::RS_2T-1];

    // Lowest coefficient has nothing shifted in
    assign rem_next[0] = fec_pkg::gf_mul(fb, fec_pkg::RS_GEN[0]);

    // Shift remainder up, add fb * g[j]
    for (genvar j = 1; j < fec_pkg::RS_2T; j++) begin : g_shift
        assign rem_next[j] = rem_in[j-1] ^ fec_pkg::gf_mul(fb, fec_pkg::RS_GEN[j]);
    end

    // ========================================
    // Pipeline register
    // ========================================

    // Free when empty or the held block leaves this cycle
    assign in_ready = ~valid_q | out_ready;
    assign load     = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    // Block rides along unchanged beside its remainder
    always_ff @(posedge clk) begin
        if (load) begin
            blk_q <= blk_in;
            rem_q <= rem_next;
        end
    end

    assign blk_out   = blk_q;
    assign rem_out   = rem_q;
    assign out_valid = valid_q;

endmodule
